//--- rtl/trig_lut_pkg.sv
package trig_lut_pkg;

        typedef logic [8:0]  angle_deg_t;
        typedef logic [6:0]  ref_angle_t;
        typedef logic [1:0]  quadrant_t;
        typedef logic        trig_func_t;
        typedef logic [63:0] fp64_t;

        localparam trig_func_t FUNC_SINE = 1'b0;
        localparam trig_func_t FUNC_CSC  = 1'b1;

        localparam angle_deg_t FULL_TURN_DEG    = 9'd360;
        localparam angle_deg_t HALF_TURN_DEG    = 9'd180;
        localparam angle_deg_t QUARTER_TURN_DEG = 9'd90;

        localparam ref_angle_t REF_ANGLE_MAX = 7'd90;   // Last table entry

        localparam int LATENCY = 2;                     // Request to result

        // Sine table is built in fixed point before conversion to double
        localparam int          SIN_FRAC_BITS = 60;
        localparam logic [63:0] PI_Q60        = 64'h3243f6a8885a308d;
        localparam fp64_t       FP64_ONE      = 64'h3ff0000000000000;

endpackage

//--- rtl/reduced_angle_if.sv
`timescale 1ns/1ns

interface reduced_angle_if import trig_lut_pkg::*; ();

        logic       valid;
        trig_func_t func;
        quadrant_t  quad;
        ref_angle_t ref_angle;          // 0 to 90
        logic       out_of_range;

        modport driver (
                output valid,
                output func,
                output quad,
                output ref_angle,
                output out_of_range
        );

        modport lut (
                input  valid,
                input  func,
                input  quad,
                input  ref_angle,
                input  out_of_range
        );

endinterface

//--- rtl/angle_reducer.sv
`timescale 1ns/1ns

module angle_reducer import trig_lut_pkg::*;
(
        input  logic            clk,
        input  logic            arst_n,
        input  logic            req_valid,
        input  trig_func_t      req_func,
        input  angle_deg_t      req_angle,
        reduced_angle_if.driver red
);

        quadrant_t  quad_c;
        ref_angle_t ref_c;
        logic       range_c;

        always_comb
        begin
                range_c = 1'b0;
                if (req_angle < QUARTER_TURN_DEG)
                begin
                        quad_c = 2'd0;
                        ref_c  = ref_angle_t'(req_angle);
                end
                else if (req_angle < HALF_TURN_DEG)
                begin
                        quad_c = 2'd1;
                        ref_c  = ref_angle_t'(HALF_TURN_DEG - req_angle);
                end
                else if (req_angle < HALF_TURN_DEG + QUARTER_TURN_DEG)
                begin
                        quad_c = 2'd2;
                        ref_c  = ref_angle_t'(req_angle - HALF_TURN_DEG);
                end
                else if (req_angle < FULL_TURN_DEG)
                begin
                        quad_c = 2'd3;
                        ref_c  = ref_angle_t'(FULL_TURN_DEG - req_angle);
                end
                else
                begin
                        quad_c  = 2'd0;         // Result is forced to zero later
                        ref_c   = '0;
                        range_c = 1'b1;
                end
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        red.valid <= 1'b0;
                else
                        red.valid <= req_valid;
        end

        always_ff @(posedge clk)
        begin
                if (req_valid)
                begin
                        red.func         <= req_func;
                        red.quad         <= quad_c;
                        red.ref_angle    <= ref_c;
                        red.out_of_range <= range_c;
                end
        end

endmodule

//--- rtl/cosecant_lut.sv
`timescale 1ns/1ns

module cosecant_lut import trig_lut_pkg::*;
(
        input  logic       clk,
        input  logic       enable,
        input  quadrant_t  quad,
        input  ref_angle_t ref_angle,
        output fp64_t      data
);

        logic [62:0] mag_c;
        logic        hit_c;

        always_comb
        begin
                hit_c = 1'b1;
                case (ref_angle)
                        7'd0:  mag_c = 63'h7ff0000000000000;    // Infinity
                        7'd1:  mag_c = 63'h404ca63b6cba7b71;
                        7'd2:  mag_c = 63'h403ca7596e271c86;
                        7'd3:  mag_c = 63'h40331b797e990dc0;
                        7'd4:  mag_c = 63'h402cabd2100d036c;
                        7'd5:  mag_c = 63'h4026f28a8ae3ab08;
                        7'd6:  mag_c = 63'h4023222ff85e6006;
                        7'd7:  mag_c = 63'h402069387b617567;
                        7'd8:  mag_c = 63'h401cbdbe5febffb0;
                        7'd9:  mag_c = 63'h401991df41de341d;
                        7'd10: mag_c = 63'h401708fb2129168e;
                        7'd11: mag_c = 63'h4014f69f90704701;
                        7'd12: mag_c = 63'h40133d2b00047f03;
                        7'd13: mag_c = 63'h4011c819f29be025;
                        7'd14: mag_c = 63'h401088c56499f439;
                        7'd15: mag_c = 63'h400ee8dd4748bf16;
                        7'd16: mag_c = 63'h400d060d6ac58d68;
                        7'd17: mag_c = 63'h400b5cc824ec982e;
                        7'd18: mag_c = 63'h4009e3779b97f4a8;
                        7'd19: mag_c = 63'h4008928aa26c4c08;
                        7'd20: mag_c = 63'h400763f38fb4cf95;
                        7'd21: mag_c = 63'h400652cbf905707a;
                        7'd22: mag_c = 63'h40055b11998752c1;
                        7'd23: mag_c = 63'h40047974b96de77f;
                        7'd24: mag_c = 63'h4003ab32fb93a3a7;
                        7'd25: mag_c = 63'h4002edfb187b1137;
                        7'd26: mag_c = 63'h40023fd71f682341;
                        7'd27: mag_c = 63'h40019f1b8c9526f0;
                        7'd28: mag_c = 63'h40010a59ff3c94be;
                        7'd29: mag_c = 63'h40008056af82561d;
                        7'd30: mag_c = 63'h4000000000000001;
                        7'd31: mag_c = 63'h3fff10cf62336e31;
                        7'd32: mag_c = 63'h3ffe317ab5700fce;
                        7'd33: mag_c = 63'h3ffd6093ce555fa8;
                        7'd34: mag_c = 63'h3ffc9cd7b485648a;
                        7'd35: mag_c = 63'h3ffbe52877982347;
                        7'd36: mag_c = 63'h3ffb38880b4603e4;
                        7'd37: mag_c = 63'h3ffa9613f8fd7862;
                        7'd38: mag_c = 63'h3ff9fd01bf93f3a3;
                        7'd39: mag_c = 63'h3ff96c9bc1d2abfe;
                        7'd40: mag_c = 63'h3ff8e43eaadf9334;
                        7'd41: mag_c = 63'h3ff863573463a809;
                        7'd42: mag_c = 63'h3ff7e9603e24eb24;
                        7'd43: mag_c = 63'h3ff775e129d20b11;
                        7'd44: mag_c = 63'h3ff7086c7026f77e;
                        7'd45: mag_c = 63'h3ff6a09e667f3bcd;
                        7'd46: mag_c = 63'h3ff63e1c2d781ada;
                        7'd47: mag_c = 63'h3ff5e092c2857578;
                        7'd48: mag_c = 63'h3ff587b62f6162b4;
                        7'd49: mag_c = 63'h3ff53340d31354d5;
                        7'd50: mag_c = 63'h3ff4e2f2c0fa463b;
                        7'd51: mag_c = 63'h3ff4969132d53892;
                        7'd52: mag_c = 63'h3ff44de60b3c3d86;
                        7'd53: mag_c = 63'h3ff408bf665efb99;
                        7'd54: mag_c = 63'h3ff3c6ef372fe94f;
                        7'd55: mag_c = 63'h3ff3884aef684af8;
                        7'd56: mag_c = 63'h3ff34cab310ac280;
                        7'd57: mag_c = 63'h3ff313eb883ae677;
                        7'd58: mag_c = 63'h3ff2ddea2c696f6a;
                        7'd59: mag_c = 63'h3ff2aa87c7f7612b;
                        7'd60: mag_c = 63'h3ff279a74590331d;
                        7'd61: mag_c = 63'h3ff24b2da2943b49;
                        7'd62: mag_c = 63'h3ff21f01c602373d;
                        7'd63: mag_c = 63'h3ff1f50c5b61511e;
                        7'd64: mag_c = 63'h3ff1cd37b13ce9c7;
                        7'd65: mag_c = 63'h3ff1a76f9ad128b7;
                        7'd66: mag_c = 63'h3ff183a154932d8b;
                        7'd67: mag_c = 63'h3ff161bb6b4a03f3;
                        7'd68: mag_c = 63'h3ff141ada5766663;
                        7'd69: mag_c = 63'h3ff12368eecf1f68;
                        7'd70: mag_c = 63'h3ff106df459ea073;
                        7'd71: mag_c = 63'h3ff0ec03a9d451e4;
                        7'd72: mag_c = 63'h3ff0d2ca0da1530d;
                        7'd73: mag_c = 63'h3ff0bb27477cf20f;
                        7'd74: mag_c = 63'h3ff0a51105712a50;
                        7'd75: mag_c = 63'h3ff0907dc1930690;
                        7'd76: mag_c = 63'h3ff07d64b78dea34;
                        7'd77: mag_c = 63'h3ff06bbddb2b91b8;
                        7'd78: mag_c = 63'h3ff05b81cfc51885;
                        7'd79: mag_c = 63'h3ff04ca9e08b8cb6;
                        7'd80: mag_c = 63'h3ff03f2ff9989907;
                        7'd81: mag_c = 63'h3ff0330ea1b99998;
                        7'd82: mag_c = 63'h3ff02840f4e91085;
                        7'd83: mag_c = 63'h3ff01ec29f6be927;
                        7'd84: mag_c = 63'h3ff0168fd9895209;
                        7'd85: mag_c = 63'h3ff00fa563d53203;
                        7'd86: mag_c = 63'h3ff00a008406617c;
                        7'd87: mag_c = 63'h3ff0059f0252e0bc;
                        7'd88: mag_c = 63'h3ff0027f274d432f;
                        7'd89: mag_c = 63'h3ff0009fba3f7835;
                        7'd90: mag_c = 63'h3ff0000000000000;
                        default:
                        begin
                                hit_c = 1'b0;
                                mag_c = '0;
                        end
                endcase
        end

        // Negative in third and fourth quadrants
        always_ff @(posedge clk)
        begin
                if (enable)
                        data <= {quad[1] & hit_c, mag_c};
        end

endmodule

//--- rtl/sine_lut.sv
`timescale 1ns/1ns

module sine_lut import trig_lut_pkg::*;
(
        input  logic       clk,
        input  logic       enable,
        input  quadrant_t  quad,
        input  ref_angle_t ref_angle,
        output fp64_t      data
);

        typedef logic [62:0]               mag_t;
        typedef mag_t [REF_ANGLE_MAX:0]    mag_rom_t;

        // Taylor series in Q.60, enough terms to settle below one LSB
        function automatic logic [127:0] sine_fixed(input int deg);
                logic [127:0] x;
                logic [127:0] x2;
                logic [127:0] term;
                logic [127:0] sum;
                x    = (128'(PI_Q60) * 128'(deg)) / 128'd180;
                x2   = (x * x) >> SIN_FRAC_BITS;
                term = x;
                sum  = x;
                for (int n = 1; n <= 12; n++)
                begin
                        term = ((term * x2) >> SIN_FRAC_BITS) / 128'((2 * n) * (2 * n + 1));
                        if (n % 2 == 1)
                                sum = sum - term;
                        else
                                sum = sum + term;
                end
                return sum;
        endfunction

        // Normalize a positive fixed point value to exponent and fraction
        function automatic mag_t to_magnitude(input logic [127:0] fix);
                int           msb;
                logic [127:0] norm;
                logic [10:0]  expo;
                msb = 0;
                for (int i = 0; i < 64; i++)
                begin
                        if (fix[i])
                                msb = i;
                end
                if (msb >= 52)
                        norm = fix >> (msb - 52);
                else
                        norm = fix << (52 - msb);
                expo = 11'(1023 + msb - SIN_FRAC_BITS);
                return {expo, norm[51:0]};
        endfunction

        function automatic mag_rom_t build_rom();
                mag_rom_t rom;
                for (int d = 0; d <= REF_ANGLE_MAX; d++)
                begin
                        if (d == 0)
                        begin
                                rom[d] = '0;
                        end
                        else if (d == REF_ANGLE_MAX)
                        begin
                                rom[d] = FP64_ONE[62:0];        // Exactly one
                        end
                        else
                        begin
                                rom[d] = to_magnitude(sine_fixed(d));
                        end
                end
                return rom;
        endfunction

        localparam mag_rom_t SINE_ROM = build_rom();

        always_ff @(posedge clk)
        begin
                if (enable)
                begin
                        if (ref_angle > REF_ANGLE_MAX)
                                data <= '0;
                        else
                                data <= {quad[1], SINE_ROM[ref_angle]};   // Sign from quadrant
                end
        end

endmodule

//--- rtl/trig_lut_bank.sv
`timescale 1ns/1ns

module trig_lut_bank import trig_lut_pkg::*;
(
        input  logic            clk,
        input  logic            arst_n,
        reduced_angle_if.lut    red,
        output logic            res_valid,
        output fp64_t           res_data,
        output logic            res_range_err
);

        logic       sine_en;
        logic       csc_en;
        fp64_t      sine_data;
        fp64_t      csc_data;
        trig_func_t func_q;

        // Idle table keeps its last value
        assign sine_en = red.valid && (red.func == FUNC_SINE);
        assign csc_en  = red.valid && (red.func == FUNC_CSC);

        sine_lut u_sine (
                .clk       (clk),
                .enable    (sine_en),
                .quad      (red.quad),
                .ref_angle (red.ref_angle),
                .data      (sine_data)
        );

        cosecant_lut u_csc (
                .clk       (clk),
                .enable    (csc_en),
                .quad      (red.quad),
                .ref_angle (red.ref_angle),
                .data      (csc_data)
        );

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        res_valid <= 1'b0;
                else
                        res_valid <= red.valid;
        end

        always_ff @(posedge clk)
        begin
                if (red.valid)
                begin
                        func_q        <= red.func;
                        res_range_err <= red.out_of_range;
                end
        end

        assign res_data = res_range_err ? '0 : ((func_q == FUNC_CSC) ? csc_data : sine_data);

endmodule

//--- rtl/trig_lut_top.sv
`timescale 1ns/1ns

module trig_lut_top import trig_lut_pkg::*;
(
        input  logic       clk,
        input  logic       arst_n,
        input  logic       req_valid,
        input  trig_func_t req_func,
        input  angle_deg_t req_angle,
        output logic       res_valid,
        output fp64_t      res_data,
        output logic       res_range_err
);

        reduced_angle_if red ();        // Reducer to table stage

        angle_reducer u_reducer (
                .clk       (clk),
                .arst_n    (arst_n),
                .req_valid (req_valid),
                .req_func  (req_func),
                .req_angle (req_angle),
                .red       (red)
        );

        trig_lut_bank u_bank (
                .clk           (clk),
                .arst_n        (arst_n),
                .red           (red),
                .res_valid     (res_valid),
                .res_data      (res_data),
                .res_range_err (res_range_err)
        );

endmodule

//--- verification/trig_lut_checker.sv
`timescale 1ns/1ns

module trig_lut_checker import trig_lut_pkg::*;
(
        input  logic       clk,
        input  logic       arst_n,
        input  logic       req_valid,
        input  trig_func_t req_func,
        input  angle_deg_t req_angle,
        input  logic       res_valid,
        input  fp64_t      res_data,
        input  logic       res_range_err,
        output int         mismatch_count,
        output int         error_count,
        output int         result_count
);

        localparam real PI = 3.14159265358979323846;

        logic [LATENCY-1:0] pipe_valid;
        angle_deg_t         pipe_angle [LATENCY];
        trig_func_t         pipe_func  [LATENCY];
        angle_deg_t         exp_angle;
        trig_func_t         exp_func;
        logic               exp_range, exp_exact, exp_neg, tol_ok, have_result;
        fp64_t              exp_bits, last_data;
        real                exp_real, got_real, diff;
        int                 valid_errs = 0, range_errs = 0, bits_errs = 0;
        int                 value_errs = 0, sign_errs = 0, hold_errs = 0;

        function automatic real true_value(input trig_func_t f, input angle_deg_t a);
                real s;
                s = $sin(PI * a / 180.0);
                if (f == FUNC_CSC)
                        return 1.0 / s;
                else
                        return s;
        endfunction

        // Zero, infinity and out-of-range results have fixed bit patterns
        function automatic fp64_t exact_bits(input trig_func_t f, input angle_deg_t a);
                if (a >= FULL_TURN_DEG)
                        return '0;
                else if (f == FUNC_CSC)
                        return {a >= HALF_TURN_DEG, 11'h7ff, 52'h0};
                else
                        return {a >= HALF_TURN_DEG, 63'h0};
        endfunction

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        pipe_valid <= '0;
                else
                        pipe_valid <= {pipe_valid[LATENCY-2:0], req_valid};
        end

        always_ff @(posedge clk)
        begin
                pipe_angle[0] <= req_angle;
                pipe_func[0]  <= req_func;
                for (int i = 1; i < LATENCY; i++)
                begin
                        pipe_angle[i] <= pipe_angle[i-1];
                        pipe_func[i]  <= pipe_func[i-1];
                end
                if (res_valid)
                        last_data <= res_data;
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        have_result  <= 1'b0;
                        result_count <= 0;
                end
                else if (res_valid)
                begin
                        have_result  <= 1'b1;
                        result_count <= result_count + 1;
                end
        end

        always_comb
        begin
                exp_angle = pipe_angle[LATENCY-1];
                exp_func  = pipe_func[LATENCY-1];
                exp_range = exp_angle >= FULL_TURN_DEG;
                exp_neg   = exp_angle >= HALF_TURN_DEG;
                exp_exact = exp_range || exp_angle == 9'd0 || exp_angle == HALF_TURN_DEG;
                exp_bits  = exact_bits(exp_func, exp_angle);
                exp_real  = exp_exact ? 0.0 : true_value(exp_func, exp_angle);
                got_real  = $bitstoreal(res_data);
                diff      = got_real - exp_real;
                if (diff < 0.0)
                        diff = -diff;
                tol_ok    = diff <= 1.0e-12 * (exp_real < 0.0 ? -exp_real : exp_real);
        end

        valid_chk: assert property (@(posedge clk) disable iff (!arst_n)
                res_valid == pipe_valid[LATENCY-1])
        else begin
                $display("MISMATCH res_valid: got %h expected %h", res_valid,
                         pipe_valid[LATENCY-1]);
                valid_errs++;
        end

        range_chk: assert property (@(posedge clk) disable iff (!arst_n)
                res_valid |-> res_range_err == exp_range)
        else begin
                $display("MISMATCH res_range_err: angle %0d got %h expected %h",
                         exp_angle, res_range_err, exp_range);
                range_errs++;
        end

        bits_chk: assert property (@(posedge clk) disable iff (!arst_n)
                (res_valid && exp_exact) |-> res_data == exp_bits)
        else begin
                $display("MISMATCH res_data: angle %0d got %h expected %h",
                         exp_angle, res_data, exp_bits);
                bits_errs++;
        end

        value_chk: assert property (@(posedge clk) disable iff (!arst_n)
                (res_valid && !exp_exact) |-> tol_ok)
        else begin
                $display("MISMATCH res_data: angle %0d got %h expected %h",
                         exp_angle, res_data, $realtobits(exp_real));
                value_errs++;
        end

        sign_chk: assert property (@(posedge clk) disable iff (!arst_n)
                (res_valid && !exp_range) |-> res_data[63] == exp_neg)
        else begin
                $display("MISMATCH res_data[63]: angle %0d got %h expected %h",
                         exp_angle, res_data[63], exp_neg);
                sign_errs++;
        end

        hold_chk: assert property (@(posedge clk) disable iff (!arst_n)
                (!res_valid && have_result) |-> res_data == last_data)
        else begin
                $display("MISMATCH res_data: got %h expected %h while res_valid low",
                         res_data, last_data);
                hold_errs++;
        end

        assign mismatch_count = valid_errs + range_errs + bits_errs + value_errs + sign_errs;
        assign error_count    = hold_errs;

endmodule

//--- verification/trig_lut_tb.sv
`timescale 1ns/1ns

module trig_lut_tb import trig_lut_pkg::*;
();

        localparam int DRAIN          = LATENCY + 1;
        localparam int RAND_REQS      = 200;
        localparam int STIM_CYCLES    = 11 + 2 * (360 + DRAIN) + RAND_REQS * 4 + DRAIN
                                        + 152 + DRAIN + 24;
        localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;

        logic        clk = 1'b0;
        logic        arst_n, req_valid, res_valid, res_range_err;
        trig_func_t  req_func;
        angle_deg_t  req_angle;
        fp64_t       res_data;
        int          mismatch_count, error_count, result_count;
        int          fails_before;
        int          cycle_count = 0;
        logic [31:0] lfsr_state = 32'hb7c6aec9;

        trig_lut_top UUT (
                .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req_func(req_func),
                .req_angle(req_angle), .res_valid(res_valid), .res_data(res_data),
                .res_range_err(res_range_err)
        );

        trig_lut_checker chk (
                .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req_func(req_func),
                .req_angle(req_angle), .res_valid(res_valid), .res_data(res_data),
                .res_range_err(res_range_err), .mismatch_count(mismatch_count),
                .error_count(error_count), .result_count(result_count)
        );

        always #10 clk = ~clk;

        always @(posedge clk)
        begin
                cycle_count = cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES)
                begin
                        $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
                        $display("Result: FAILED");
                        $finish;
                end
        end

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                if (s[0])
                        return (s >> 1) ^ 32'h80200003;
                else
                        return s >> 1;
        endfunction

        function automatic logic [31:0] take_bits(input int n);
                logic [31:0] bits;
                bits = '0;
                for (int i = 0; i < n; i++)
                begin
                        lfsr_state = lfsr_next(lfsr_state);
                        bits       = {bits[30:0], lfsr_state[0]};
                end
                return bits;
        endfunction

        task automatic send_req(input trig_func_t func, input angle_deg_t angle);
                req_valid = 1'b1;
                req_func  = func;
                req_angle = angle;
                @(posedge clk);
                #1;
        endtask

        task automatic idle(input int n);
                req_valid = 1'b0;
                repeat (n)
                begin
                        @(posedge clk);
                        #1;
                end
        endtask

        task automatic end_test(input string name);
                int fails_now;
                idle(DRAIN);                            // Fixed two-stage latency
                fails_now = mismatch_count + error_count;
                if (fails_now == fails_before)
                        $display("%s: ok", name);
                else
                        $display("%s: %0d failures", name, fails_now - fails_before);
                fails_before = fails_now;
        endtask

        initial
        begin
                arst_n       = 1'b0;
                req_valid    = 1'b0;
                req_func     = FUNC_SINE;
                req_angle    = '0;
                fails_before = 0;
                repeat (3) @(posedge clk);
                #1 arst_n = 1'b1;

                idle(4);                                // res_valid must stay low
                send_req(FUNC_SINE, 9'd30);
                end_test("reset_and_latency");

                for (int a = 0; a < 360; a++)
                        send_req(FUNC_SINE, angle_deg_t'(a));
                end_test("sine_sweep");

                for (int a = 0; a < 360; a++)
                        send_req(FUNC_CSC, angle_deg_t'(a));
                end_test("cosecant_sweep");

                for (int i = 0; i < RAND_REQS; i++)
                begin
                        send_req(trig_func_t'(take_bits(1)), angle_deg_t'(take_bits(9) % 360));
                        idle(int'(take_bits(2)));
                end
                end_test("random_mix");

                for (int a = 360; a < 512; a++)
                        send_req(trig_func_t'(a % 2), angle_deg_t'(a));
                end_test("out_of_range");

                send_req(FUNC_CSC, 9'd45);
                idle(6);
                send_req(FUNC_SINE, 9'd210);
                idle(5);
                send_req(FUNC_SINE, 9'd400);            // Held zero after a range error
                idle(4);
                end_test("idle_hold");

                $display("Summary: %0d results, %0d mismatches, %0d errors",
                         result_count, mismatch_count, error_count);
                if (mismatch_count + error_count == 0)
                        $display("Result: PASSED");
                else
                        $display("Result: FAILED");
                $finish;
        end

endmodule

//--- build.f
rtl/trig_lut_pkg.sv
rtl/reduced_angle_if.sv
rtl/angle_reducer.sv
rtl/cosecant_lut.sv
rtl/sine_lut.sv
rtl/trig_lut_bank.sv
rtl/trig_lut_top.sv
verification/trig_lut_checker.sv
verification/trig_lut_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module trig_lut_tb -f build.f -o trig_lut_sim

./obj_dir/trig_lut_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0
